//--- src/frontend_pkg.sv
package frontend_pkg;

    localparam int ADDR_WIDTH  = 32;
    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c00_0000;

    localparam int LINE_WORDS  = 4;
    localparam int LINE_WIDTH  = 128;
    localparam int BTB_ENTRIES = 8;
    localparam int FTQ_DEPTH   = 4;
    localparam int OBUF_DEPTH  = 4;

    // Derived field widths
    localparam int SLOT_WIDTH    = $clog2(LINE_WORDS);
    localparam int LEN_WIDTH     = $clog2(LINE_WORDS + 1);
    localparam int OFFSET_WIDTH  = $clog2(LINE_WIDTH / 8);
    localparam int BTB_IDX_WIDTH = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - BTB_IDX_WIDTH;

    // One predicted fetch block, never crossing a line
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [LEN_WIDTH-1:0]  len;
        logic [ADDR_WIDTH-1:0] line_addr;
    } fetch_block_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        logic [ADDR_WIDTH-1:0] instr;
    } instr_pkt_t;

endpackage

//--- src/ftq_if.sv
`timescale 1ns/1ps

interface ftq_if
    import frontend_pkg::*;
();

    logic         valid;
    fetch_block_t block;
    logic         accept;
    // Consumer drops its current block
    logic         flush;

    modport producer (
        output valid,
        output block,
        output flush,
        input  accept
    );

    modport consumer (
        input  valid,
        input  block,
        input  flush,
        output accept
    );

endinterface

//--- src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,

    input  logic flush_i,

    input  logic push_i,
    input  T     data_i,

    input  logic pop_i,
    output T     data_o,
    output logic empty_o,
    output logic full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign data_o  = mem[rd_ptr];

    // Flush wins over both ends
    assign do_push = push_i & ~full_o & ~flush_i;
    assign do_pop  = pop_i & ~empty_o & ~flush_i;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- src/pc_ctrl.sv
`timescale 1ns/1ps

module pc_ctrl
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  backend_flush_i,
    input  logic [ADDR_WIDTH-1:0] backend_pc_i,

    input  logic                  pred_hit_i,
    input  logic [LEN_WIDTH-1:0]  pred_len_i,
    input  logic [ADDR_WIDTH-1:0] pred_target_i,

    input  logic                  ftq_full_i,

    output logic [ADDR_WIDTH-1:0] pc_o,
    output fetch_block_t          block_o,
    output logic                  block_push_o
);

    logic [ADDR_WIDTH-1:0] pc_q;
    logic [ADDR_WIDTH-1:0] pc_d;
    logic [ADDR_WIDTH-1:0] seq_pc;

    assign pc_o = pc_q;

    // Block runs from the PC to the predicted branch or the line end
    assign block_o.start_pc  = pc_q;
    assign block_o.len       = pred_len_i;
    assign block_o.line_addr = {pc_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    assign block_push_o = ~ftq_full_i & ~backend_flush_i;

    assign seq_pc = pc_q + ADDR_WIDTH'({pred_len_i, 2'b00});

    always_comb begin
        if (backend_flush_i) begin
            pc_d = backend_pc_i;
        end else if (ftq_full_i) begin
            pc_d = pc_q;
        end else if (pred_hit_i) begin
            pc_d = pred_target_i;
        end else begin
            pc_d = seq_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

endmodule

//--- src/btb_predictor.sv
`timescale 1ns/1ps

module btb_predictor
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [ADDR_WIDTH-1:0] pc_i,

    output logic                  hit_o,
    output logic [LEN_WIDTH-1:0]  len_o,
    output logic [ADDR_WIDTH-1:0] target_o,

    input  logic                  backend_update_valid_i,
    input  logic [ADDR_WIDTH-1:0] backend_update_pc_i,
    input  logic [ADDR_WIDTH-1:0] backend_update_target_i,
    input  logic                  backend_update_taken_i
);

    localparam int IDX_LO = OFFSET_WIDTH;
    localparam int TAG_LO = OFFSET_WIDTH + BTB_IDX_WIDTH;

    logic                     entry_valid  [BTB_ENTRIES];
    logic [BTB_TAG_WIDTH-1:0] entry_tag    [BTB_ENTRIES];
    logic [SLOT_WIDTH-1:0]    entry_slot   [BTB_ENTRIES];
    logic [ADDR_WIDTH-1:0]    entry_target [BTB_ENTRIES];

    logic [BTB_IDX_WIDTH-1:0] rd_idx;
    logic [BTB_TAG_WIDTH-1:0] rd_tag;
    logic [SLOT_WIDTH-1:0]    rd_slot;
    logic [BTB_IDX_WIDTH-1:0] wr_idx;
    logic [BTB_TAG_WIDTH-1:0] wr_tag;

    assign rd_idx  = pc_i[TAG_LO-1:IDX_LO];
    assign rd_tag  = pc_i[ADDR_WIDTH-1:TAG_LO];
    assign rd_slot = pc_i[OFFSET_WIDTH-1:2];

    // Branch must sit at or after the fetch slot to cut this block
    assign hit_o = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag)
                   && (entry_slot[rd_idx] >= rd_slot);

    assign target_o = entry_target[rd_idx];

    always_comb begin
        if (hit_o) begin
            len_o = LEN_WIDTH'(entry_slot[rd_idx]) - LEN_WIDTH'(rd_slot) + LEN_WIDTH'(1);
        end else begin
            len_o = LEN_WIDTH'(LINE_WORDS) - LEN_WIDTH'(rd_slot);
        end
    end

    assign wr_idx = backend_update_pc_i[TAG_LO-1:IDX_LO];
    assign wr_tag = backend_update_pc_i[ADDR_WIDTH-1:TAG_LO];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else if (backend_update_valid_i) begin
            if (backend_update_taken_i) begin
                entry_valid[wr_idx] <= 1'b1;
            end else if (entry_tag[wr_idx] == wr_tag) begin
                entry_valid[wr_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (backend_update_valid_i && backend_update_taken_i) begin
            entry_tag[wr_idx]    <= wr_tag;
            entry_slot[wr_idx]   <= backend_update_pc_i[OFFSET_WIDTH-1:2];
            entry_target[wr_idx] <= backend_update_target_i;
        end
    end

endmodule

//--- src/ifu.sv
`timescale 1ns/1ps

module ifu
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    ftq_if.consumer               blk,

    output logic                  icache_req_o,
    output logic [ADDR_WIDTH-1:0] icache_addr_o,
    input  logic                  icache_ack_i,
    input  logic [LINE_WIDTH-1:0] icache_data_i,

    output logic                  out_push_o,
    output instr_pkt_t            out_pkt_o,
    input  logic                  out_full_i
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        EMIT
    } state_t;

    state_t state_q;
    state_t state_d;

    // Set when a flush hits an open handshake
    logic discard_q;

    fetch_block_t          block_q;
    logic [LINE_WIDTH-1:0] line_q;
    logic [SLOT_WIDTH-1:0] slot_q;
    logic [LEN_WIDTH-1:0]  cnt_q;
    logic                  take_blk;
    logic                  last_instr;

    assign take_blk   = (state_q == IDLE) & blk.valid & ~blk.flush;
    assign blk.accept = take_blk;

    assign icache_req_o  = (state_q == REQ);
    assign icache_addr_o = block_q.line_addr;

    assign out_push_o = (state_q == EMIT) & ~out_full_i & ~blk.flush;
    assign last_instr = (cnt_q == LEN_WIDTH'(1));

    assign out_pkt_o.pc    = {block_q.line_addr[ADDR_WIDTH-1:OFFSET_WIDTH], slot_q, 2'b00};
    assign out_pkt_o.instr = line_q[slot_q*ADDR_WIDTH +: ADDR_WIDTH];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take_blk) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (icache_ack_i) begin
                    state_d = WAIT_ACK_LOW;
                end
            end
            WAIT_ACK_LOW: begin
                if (!icache_ack_i) begin
                    state_d = (discard_q || blk.flush) ? IDLE : EMIT;
                end
            end
            EMIT: begin
                if (blk.flush) begin
                    state_d = IDLE;
                end else if (out_push_o && last_instr) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            discard_q <= 1'b0;
            slot_q    <= '0;
            cnt_q     <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == WAIT_ACK_LOW && !icache_ack_i) begin
                discard_q <= 1'b0;
            end else if (blk.flush && (state_q == REQ || state_q == WAIT_ACK_LOW)) begin
                discard_q <= 1'b1;
            end
            if (take_blk) begin
                slot_q <= blk.block.start_pc[OFFSET_WIDTH-1:2];
                cnt_q  <= blk.block.len;
            end else if (out_push_o) begin
                slot_q <= slot_q + 1'b1;
                cnt_q  <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_blk) begin
            block_q <= blk.block;
        end
        if (state_q == REQ && icache_ack_i) begin
            line_q <= icache_data_i;
        end
    end

endmodule

//--- src/frontend.sv
`timescale 1ns/1ps

module frontend
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // Instruction cache
    output logic                  icache_req_o,
    output logic [ADDR_WIDTH-1:0] icache_addr_o,
    input  logic                  icache_ack_i,
    input  logic [LINE_WIDTH-1:0] icache_data_i,

    // Backend redirect and training
    input  logic                  backend_flush_i,
    input  logic [ADDR_WIDTH-1:0] backend_pc_i,
    input  logic                  backend_update_valid_i,
    input  logic [ADDR_WIDTH-1:0] backend_update_pc_i,
    input  logic [ADDR_WIDTH-1:0] backend_update_target_i,
    input  logic                  backend_update_taken_i,

    // Instruction buffer
    output logic                  instr_valid_o,
    output logic [ADDR_WIDTH-1:0] instr_pc_o,
    output logic [ADDR_WIDTH-1:0] instr_o,
    input  logic                  stall_i
);

    logic [ADDR_WIDTH-1:0] pc;
    logic                  pred_hit;
    logic [LEN_WIDTH-1:0]  pred_len;
    logic [ADDR_WIDTH-1:0] pred_target;

    fetch_block_t          new_block;
    logic                  block_push;
    logic                  ftq_full;
    logic                  ftq_empty;
    fetch_block_t          ftq_head;

    logic                  out_push;
    instr_pkt_t            out_pkt;
    logic                  obuf_full;
    logic                  obuf_empty;
    instr_pkt_t            obuf_head;

    ftq_if ftq_bus ();

    // FTQ side of the block channel
    assign ftq_bus.valid = ~ftq_empty;
    assign ftq_bus.block = ftq_head;
    assign ftq_bus.flush = backend_flush_i;

    assign instr_valid_o = ~obuf_empty;
    assign instr_pc_o    = obuf_head.pc;
    assign instr_o       = obuf_head.instr;

    pc_ctrl u_pc_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .backend_flush_i(backend_flush_i),
        .backend_pc_i   (backend_pc_i),
        .pred_hit_i     (pred_hit),
        .pred_len_i     (pred_len),
        .pred_target_i  (pred_target),
        .ftq_full_i     (ftq_full),
        .pc_o           (pc),
        .block_o        (new_block),
        .block_push_o   (block_push)
    );

    btb_predictor u_btb (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .pc_i                   (pc),
        .hit_o                  (pred_hit),
        .len_o                  (pred_len),
        .target_o               (pred_target),
        .backend_update_valid_i (backend_update_valid_i),
        .backend_update_pc_i    (backend_update_pc_i),
        .backend_update_target_i(backend_update_target_i),
        .backend_update_taken_i (backend_update_taken_i)
    );

    sync_fifo #(
        .T    (fetch_block_t),
        .DEPTH(FTQ_DEPTH)
    ) u_ftq (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush_i(backend_flush_i),
        .push_i (block_push),
        .data_i (new_block),
        .pop_i  (ftq_bus.accept),
        .data_o (ftq_head),
        .empty_o(ftq_empty),
        .full_o (ftq_full)
    );

    ifu u_ifu (
        .clk          (clk),
        .rst_n        (rst_n),
        .blk          (ftq_bus.consumer),
        .icache_req_o (icache_req_o),
        .icache_addr_o(icache_addr_o),
        .icache_ack_i (icache_ack_i),
        .icache_data_i(icache_data_i),
        .out_push_o   (out_push),
        .out_pkt_o    (out_pkt),
        .out_full_i   (obuf_full)
    );

    // Head leaves on every cycle the buffer does not stall
    sync_fifo #(
        .T    (instr_pkt_t),
        .DEPTH(OBUF_DEPTH)
    ) u_obuf (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush_i(backend_flush_i),
        .push_i (out_push),
        .data_i (out_pkt),
        .pop_i  (instr_valid_o & ~stall_i),
        .data_o (obuf_head),
        .empty_o(obuf_empty),
        .full_o (obuf_full)
    );

endmodule

//--- tb/icache_model.sv
`timescale 1ns/1ps

module icache_model
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    output logic                  ack_o,
    output logic [LINE_WIDTH-1:0] data_o
);

    localparam logic [ADDR_WIDTH-1:0] DATA_KEY = 32'ha5a5_a5a5;

    // Word i of the line sits in bits [32*i +: 32]
    function automatic logic [LINE_WIDTH-1:0] line_data(input logic [ADDR_WIDTH-1:0] addr);
        logic [LINE_WIDTH-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i*ADDR_WIDTH +: ADDR_WIDTH] = (addr + ADDR_WIDTH'(4 * i)) ^ DATA_KEY;
        end
        return line;
    endfunction

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        int                    delay;
        ack_o  = 1'b0;
        data_o = '0;
        wait (rst_n);
        forever begin
            @(negedge clk);
            while (!req_i) begin
                @(negedge clk);
            end
            addr  = addr_i;
            delay = $urandom % 6;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            ack_o  <= 1'b1;
            data_o <= line_data(addr);
            // Hold ack until the request drops
            @(negedge clk);
            while (req_i) begin
                @(negedge clk);
            end
            delay = $urandom % 6;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            ack_o <= 1'b0;
        end
    end

endmodule

//--- tb/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend
    import frontend_pkg::*;
();

    localparam logic [31:0] DATA_KEY    = 32'ha5a5_a5a5;
    localparam int          NUM_ROWS    = 9;
    localparam int          FIRST_COUNT = 8;

    typedef struct packed {
        logic [31:0] br_pc;
        logic [31:0] target;
        logic        taken;
        logic [31:0] start_pc;
        logic [31:0] count;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  icache_req_o;
    logic [ADDR_WIDTH-1:0] icache_addr_o;
    logic                  icache_ack_i;
    logic [LINE_WIDTH-1:0] icache_data_i;
    logic                  backend_flush_i;
    logic [ADDR_WIDTH-1:0] backend_pc_i;
    logic                  backend_update_valid_i;
    logic [ADDR_WIDTH-1:0] backend_update_pc_i;
    logic [ADDR_WIDTH-1:0] backend_update_target_i;
    logic                  backend_update_taken_i;
    logic                  instr_valid_o;
    logic [ADDR_WIDTH-1:0] instr_pc_o;
    logic [ADDR_WIDTH-1:0] instr_o;
    logic                  stall_i;

    row_t rows [NUM_ROWS];
    logic table_ready = 1'b0;

    // Reference copy of the branch target buffer
    logic        m_valid  [BTB_ENTRIES];
    logic [31:0] m_tag    [BTB_ENTRIES];
    logic [1:0]  m_slot   [BTB_ENTRIES];
    logic [31:0] m_target [BTB_ENTRIES];

    frontend u_dut (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .icache_req_o           (icache_req_o),
        .icache_addr_o          (icache_addr_o),
        .icache_ack_i           (icache_ack_i),
        .icache_data_i          (icache_data_i),
        .backend_flush_i        (backend_flush_i),
        .backend_pc_i           (backend_pc_i),
        .backend_update_valid_i (backend_update_valid_i),
        .backend_update_pc_i    (backend_update_pc_i),
        .backend_update_target_i(backend_update_target_i),
        .backend_update_taken_i (backend_update_taken_i),
        .instr_valid_o          (instr_valid_o),
        .instr_pc_o             (instr_pc_o),
        .instr_o                (instr_o),
        .stall_i                (stall_i)
    );

    icache_model u_icache (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (icache_req_o),
        .addr_i(icache_addr_o),
        .ack_o (icache_ack_i),
        .data_o(icache_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Direct map on the 16-byte line number
    function automatic int index_of(input logic [31:0] p);
        return (p >> 4) % BTB_ENTRIES;
    endfunction

    function automatic logic [31:0] tag_of(input logic [31:0] p);
        return (p >> 4) / BTB_ENTRIES;
    endfunction

    function automatic logic [31:0] predict_next(input logic [31:0] p);
        int idx;
        idx = index_of(p);
        if (m_valid[idx] && m_tag[idx] == tag_of(p) && m_slot[idx] == p[3:2]) begin
            return m_target[idx];
        end else begin
            return p + 32'd4;
        end
    endfunction

    function automatic void train_entry(input logic [31:0] br_pc, input logic [31:0] target,
                                        input logic taken);
        int idx;
        idx = index_of(br_pc);
        if (taken) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = tag_of(br_pc);
            m_slot[idx]   = br_pc[3:2];
            m_target[idx] = target;
        end else if (m_tag[idx] == tag_of(br_pc)) begin
            m_valid[idx] = 1'b0;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=0x%08h expected=0x%08h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_row(input int r, input logic [31:0] br_pc, input logic [31:0] target,
                           input logic taken, input logic [31:0] start_pc,
                           input logic [31:0] count);
        rows[r].br_pc    = br_pc;
        rows[r].target   = target;
        rows[r].taken    = taken;
        rows[r].start_pc = start_pc;
        rows[r].count    = count;
    endtask

    // Consume n instructions with random stalls and compare each one
    task automatic run_stream(input int n, input logic [31:0] start_pc);
        logic [31:0] exp_pc;
        int          got;
        exp_pc = start_pc;
        got    = 0;
        @(posedge clk);
        stall_i <= 1'b0;
        while (got < n) begin
            @(negedge clk);
            if (instr_valid_o && !stall_i) begin
                check_value("instr_pc_o", instr_pc_o, exp_pc);
                check_value("instr_o", instr_o, exp_pc ^ DATA_KEY);
                exp_pc = predict_next(exp_pc);
                got++;
            end
            @(posedge clk);
            stall_i <= (($urandom % 4) == 0);
        end
        stall_i <= 1'b1;
    endtask

    task automatic apply_row(input int r);
        int gap;
        @(posedge clk);
        backend_update_valid_i  <= 1'b1;
        backend_update_pc_i     <= rows[r].br_pc;
        backend_update_target_i <= rows[r].target;
        backend_update_taken_i  <= rows[r].taken;
        train_entry(rows[r].br_pc, rows[r].target, rows[r].taken);
        @(posedge clk);
        backend_update_valid_i <= 1'b0;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        backend_flush_i <= 1'b1;
        backend_pc_i    <= rows[r].start_pc;
        @(posedge clk);
        backend_flush_i <= 1'b0;
        run_stream(rows[r].count, rows[r].start_pc);
    endtask

    initial begin
        int seed_ret;
        seed_ret = $urandom(89);

        // Branch PC, target, taken, flush PC, instructions to check
        set_row(0, 32'h1c00_0104, 32'h1c00_0238, 1'b1, 32'h1c00_0100, 12);
        set_row(1, 32'h1c00_031c, 32'h1c00_0324, 1'b1, 32'h1c00_0300, 14);
        set_row(2, 32'h1c00_0458, 32'h1c00_0468, 1'b1, 32'h1c00_0444, 12);
        set_row(3, 32'h1c00_0104, 32'h0000_0000, 1'b0, 32'h1c00_0100, 10);
        set_row(4, 32'h1c00_0508, 32'h1c00_0620, 1'b1, 32'h1c00_0500, 8);
        set_row(5, 32'h1c00_0588, 32'h1c00_0704, 1'b1, 32'h1c00_0570, 10);
        set_row(6, 32'h1c00_0ff0, 32'h0000_0000, 1'b0, 32'h1c00_0500, 8);
        set_row(7, 32'h1c00_0ff0, 32'h0000_0000, 1'b0, 32'h1c00_0318, 6);
        set_row(8, 32'h1c00_0d08, 32'h0000_0000, 1'b0, 32'h1c00_0580, 6);
        table_ready = 1'b1;

        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '1;
            m_slot[i]   = '0;
            m_target[i] = '0;
        end

        rst_n                   = 1'b0;
        backend_flush_i         = 1'b0;
        backend_pc_i            = '0;
        backend_update_valid_i  = 1'b0;
        backend_update_pc_i     = '0;
        backend_update_target_i = '0;
        backend_update_taken_i  = 1'b0;
        stall_i                 = 1'b1;

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("icache_req_o", 32'(icache_req_o), 32'd0);
        check_value("instr_valid_o", 32'(instr_valid_o), 32'd0);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("icache_req_o", 32'(icache_req_o), 32'd0);
        check_value("instr_valid_o", 32'(instr_valid_o), 32'd0);

        // Untrained fetch straight out of reset
        run_stream(FIRST_COUNT, RESET_PC);

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end

        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = FIRST_COUNT;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += rows[r].count;
        end
        limit = limit * 40 + NUM_ROWS * 50 + 500;
        repeat (limit) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, instructions stopped arriving",
                 limit);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

//--- frontend.f
src/frontend_pkg.sv
src/ftq_if.sv
src/sync_fifo.sv
src/pc_ctrl.sv
src/btb_predictor.sv
src/ifu.sv
src/frontend.sv
tb/icache_model.sv
tb/tb_frontend.sv
